// ==== bench/core_mmu_check.sv ====
`timescale 1ns/1ps

module core_mmu_check
	import core_mmu_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,

	input  mem_req_t     core_req,
	input  logic         core_start,
	input  logic         core_ready,
	input  word          core_data_rd,
	input  logic         core_fault,

	input  logic         fault_valid,
	input  ptr           fault_status_addr,
	input  fault_cause_t fault_status_cause,

	// Expected response, set by the testbench together with core_req
	input  word          exp_data,
	input  logic         exp_fault,
	input  fault_cause_t exp_cause,

	output int           errors
);

	mem_req_t     req_q;
	word          exp_data_q;
	logic         exp_fault_q;
	fault_cause_t exp_cause_q;
	logic         status_due;

	initial errors = 0;

	always @(posedge clk) begin
		if (!rst_n) begin
			status_due <= 1'b0;
		end else begin
			if (core_start) begin
				req_q <= core_req;
				exp_data_q <= exp_data;
				exp_fault_q <= exp_fault;
				exp_cause_q <= exp_cause;
			end

			status_due <= core_ready && exp_fault_q;

			if (core_ready) begin
				if (core_fault !== exp_fault_q) begin
					$display("error t=%0t core_fault got %b expected %b (va %h)",
						$time, core_fault, exp_fault_q, req_q.addr);
					errors++;
				end else if (!exp_fault_q && !req_q.write && core_data_rd !== exp_data_q) begin
					$display("error t=%0t core_data_rd got %h expected %h (va %h)",
						$time, core_data_rd, exp_data_q, req_q.addr);
					errors++;
				end
			end

			// Status registers update one edge after the fault response
			if (status_due) begin
				if (fault_valid !== 1'b1) begin
					$display("error t=%0t fault_valid got %b expected 1", $time, fault_valid);
					errors++;
				end
				if (fault_status_addr !== req_q.addr) begin
					$display("error t=%0t fault_status_addr got %h expected %h",
						$time, fault_status_addr, req_q.addr);
					errors++;
				end
				if (fault_status_cause !== exp_cause_q) begin
					$display("error t=%0t fault_status_cause got %0d expected %0d",
						$time, fault_status_cause, exp_cause_q);
					errors++;
				end
			end
		end
	end

endmodule

// ==== bench/core_mmu_tb.sv ====
`timescale 1ns/1ps

module core_mmu_tb
	import core_mmu_pkg::*;
;

	logic         clk;
	logic         rst_n;
	logic         cfg_we;
	logic         cfg_enable;
	mmu_base      cfg_ttbr;
	logic         load_we;
	ptr           load_addr;
	word          load_data;
	mem_req_t     core_req;
	logic         core_start;
	logic         core_ready;
	word          core_data_rd;
	logic         core_fault;
	logic         fault_valid;
	ptr           fault_status_addr;
	fault_cause_t fault_status_cause;

	word          exp_data;
	logic         exp_fault;
	fault_cause_t exp_cause;
	int           check_errors;
	int           tb_errors;

	word     shadow [16384];
	logic    mmu_on;
	mmu_base ttbr;
	integer  seed;
	ptr      touched [$];

	core_mmu_top core_mmu_top_i (.*);

	core_mmu_check core_mmu_check_i (
		.clk, .rst_n, .core_req, .core_start, .core_ready, .core_data_rd, .core_fault,
		.fault_valid, .fault_status_addr, .fault_status_cause,
		.exp_data, .exp_fault, .exp_cause, .errors(check_errors)
	);

	always #50 clk = ~clk;

	// Expected physical address or fault cause from the shadow image
	function automatic fault_cause_t translate_ref(input ptr va, output ptr pa);
		mmu_l1_pagetable l1_pt;
		mmu_l1_section   l1_sec;
		mmu_l2_large     l2_lg;
		mmu_l2_small     l2_sm;
		word             d1;
		word             d2;
		ptr              a;
		pa = va;
		if (!mmu_on)
			return CAUSE_NONE;
		a = {ttbr, va[31:20], 2'b00};
		d1 = shadow[a[15:2]];
		case (d1[1:0])
			2'd0: return CAUSE_L1_FAULT;
			2'd3: return CAUSE_L1_UNSUPPORTED;
			2'd2: begin
				l1_sec = d1;
				pa = {l1_sec.base, va[19:0]};
				return CAUSE_NONE;
			end
			default: begin
				l1_pt = d1;
				a = {l1_pt.base, va[19:12], 2'b00};
				d2 = shadow[a[15:2]];
				l2_lg = d2;
				l2_sm = d2;
				if (d2[1:0] == 2'd0)
					return CAUSE_L2_FAULT;
				if (d2[1:0] == 2'd1)
					pa = {l2_lg.base, va[15:0]};
				else
					pa = {l2_sm.base, va[11:0]}; // Small and small-extended alike
				return CAUSE_NONE;
			end
		endcase
	endfunction

	task automatic load_word(input ptr a, input word d);
		load_we = 1'b1;
		load_addr = a;
		load_data = d;
		shadow[a[15:2]] = d;
		@(posedge clk);
		#1 load_we = 1'b0;
	endtask

	task automatic configure(input logic en, input mmu_base base);
		cfg_we = 1'b1;
		cfg_enable = en;
		cfg_ttbr = base;
		mmu_on = en;
		ttbr = base;
		@(posedge clk);
		#1 cfg_we = 1'b0;
	endtask

	task automatic access(input ptr va, input word d, input logic [3:0] be, input logic wr);
		ptr           pa;
		fault_cause_t cause;
		int           cnt;
		cause = translate_ref(va, pa);
		exp_fault = cause != CAUSE_NONE;
		exp_cause = cause;
		exp_data = shadow[pa[15:2]];
		core_req = '{addr: va, data_wr: d, be: be, write: wr};
		core_start = 1'b1;
		@(posedge clk);
		#1 core_start = 1'b0;
		cnt = 0;
		@(negedge clk);
		while (!core_ready && cnt < 100) begin
			@(negedge clk);
			cnt++;
		end
		if (!core_ready) begin
			$display("Timeout waiting for core_ready, va %h", va);
			$display("TEST FAILED");
			$finish;
		end
		@(posedge clk);
		#1;
		if (wr) begin
			if (cause == CAUSE_NONE)
				for (int i = 0; i < 4; i++)
					if (be[i])
						shadow[pa[15:2]][i*8 +: 8] = d[i*8 +: 8];
			touched.push_back(pa); // A fault leaves pa at the virtual address
		end
	endtask

	task automatic write_read(input ptr va);
		word        d;
		logic [3:0] be;
		d = $random(seed);
		be = 4'($random(seed));
		access(va, d, be, 1'b1);
		access(va, 32'h0, 4'h0, 1'b0);
	endtask

	function automatic ptr rand_off(input ptr mask);
		return ptr'($random(seed)) & mask & 32'hffff_fffc;
	endfunction

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		cfg_we = 1'b0;
		cfg_enable = 1'b0;
		cfg_ttbr = '0;
		load_we = 1'b0;
		load_addr = '0;
		load_data = '0;
		core_req = '0;
		core_start = 1'b0;
		exp_data = '0;
		exp_fault = 1'b0;
		exp_cause = CAUSE_NONE;
		tb_errors = 0;
		mmu_on = 1'b0;
		ttbr = '0;
		seed = 4;
		repeat (10) @(posedge clk);
		#1 rst_n = 1'b1;

		// Low two bits zero, so every unset descriptor is a fault entry
		for (int i = 0; i < 16384; i++)
			load_word(ptr'(i * 4), {~i[13:0], 2'b00, i[13:0], 2'b00});
		load_word(32'h8000 + 12'h001 * 4, {12'h123, 18'h0, MMU_L1_SECTION});
		load_word(32'h8000 + 12'h002 * 4, {22'h30, 8'h0, MMU_L1_PAGETABLE}); // L2 at 0xC000
		load_word(32'h8000 + 12'h003 * 4, {30'h0, MMU_L1_RESERVED});
		load_word(32'hc000 + 8'h10 * 4, {16'h0045, 14'h0, MMU_L2_LARGE});
		load_word(32'hc000 + 8'h21 * 4, {20'h00005, 10'h0, MMU_L2_SMALL});
		load_word(32'hc000 + 8'h22 * 4, {20'h00006, 10'h0, MMU_L2_SMALLEXT});
		load_word(32'hc000 + 8'h23 * 4, {30'h0, MMU_L2_FAULT});

		repeat (8) write_read(rand_off(32'h3fff));

		configure(1'b1, 18'd2);
		repeat (6) write_read(32'h0010_0000 | rand_off(32'h3fff));
		repeat (4) write_read(32'h0021_0000 | rand_off(32'h0fff));
		repeat (4) write_read(32'h0022_1000 | rand_off(32'h0fff));
		repeat (4) write_read(32'h0022_2000 | rand_off(32'h0fff));

		access(32'h0040_0010, 32'hdead_beef, 4'hf, 1'b1);
		access(32'h0030_0020, 32'hdead_beef, 4'hf, 1'b1);
		access(32'h0022_3030, 32'hdead_beef, 4'hf, 1'b1);

		configure(1'b1, 18'd2);
		@(negedge clk);
		if (fault_valid !== 1'b0) begin
			$display("error t=%0t fault_valid got %b expected 0", $time, fault_valid);
			tb_errors++;
		end
		@(posedge clk);
		#1 write_read(32'h0010_0000 | rand_off(32'h3fff));

		// Physical readback, also shows that faulting writes left RAM alone
		configure(1'b0, 18'd2);
		foreach (touched[i])
			access(touched[i], 32'h0, 4'h0, 1'b0);
		for (int i = 0; i < 65536; i += 256)
			access(ptr'(i), 32'h0, 4'h0, 1'b0);

		repeat (3) @(posedge clk);
		$display("Errors: %0d in checker, %0d in testbench", check_errors, tb_errors);
		if (check_errors == 0 && tb_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial begin
		#20ms;
		$display("Simulation ran past its time limit");
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== hw/core_mmu_ctrl.sv ====
`timescale 1ns/1ps

module core_mmu_ctrl
	import core_mmu_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,

	input  logic         cfg_we,
	input  logic         cfg_enable,
	input  mmu_base      cfg_ttbr,

	input  logic         fault_strobe,
	input  ptr           fault_addr,
	input  fault_cause_t fault_cause,

	output logic         mmu_enable,
	output mmu_base      mmu_ttbr,

	output logic         fault_valid,
	output ptr           fault_status_addr,
	output fault_cause_t fault_status_cause
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mmu_enable <= 1'b0;
			mmu_ttbr <= '0;
			fault_valid <= 1'b0;
		end else begin
			if (cfg_we) begin
				mmu_enable <= cfg_enable;
				mmu_ttbr <= cfg_ttbr;
			end

			// New configuration starts with a clean record
			if (cfg_we)
				fault_valid <= 1'b0;
			else if (fault_strobe)
				fault_valid <= 1'b1;
		end
	end

	// Last fault wins
	always_ff @(posedge clk) begin
		if (fault_strobe) begin
			fault_status_addr <= fault_addr;
			fault_status_cause <= fault_cause;
		end
	end

	// Walker only faults mid-access, config only arrives while idle
	cfg_vs_fault: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(cfg_we && fault_strobe)
	);

endmodule

// ==== hw/core_mmu_pagewalk.sv ====
`timescale 1ns/1ps

module core_mmu_pagewalk
	import core_mmu_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,

	input  logic         mmu_enable,
	input  mmu_base      mmu_ttbr,

	input  mem_req_t     core_req,
	input  logic         core_start,

	input  logic         bus_ready,
	input  word          bus_data_rd,

	output mem_req_t     bus_req,
	output logic         bus_start,

	output logic         core_ready,
	output word          core_data_rd,
	output logic         core_fault,

	output logic         fault_strobe,
	output ptr           fault_addr,
	output fault_cause_t fault_cause
);

	typedef enum logic [2:0] {
		IDLE,
		L1,
		L2,
		DATA,
		FAULT
	} state_t;

	state_t state;
	state_t state_next;

	mmu_l1_pagetable pagetable;
	mmu_l1_section   section;
	mmu_l2_large     ptentry_large;
	mmu_l2_small     ptentry_small;

	assign pagetable = bus_data_rd;
	assign section = bus_data_rd;
	assign ptentry_large = bus_data_rd;
	assign ptentry_small = bus_data_rd;

	mem_req_t hold; // Request latched at core_start
	mem_req_t req_src;

	ptr           bus_addr;
	word          bus_data_wr;
	logic [3:0]   bus_be;
	logic         bus_write;
	logic         data_done;
	fault_cause_t cause_q;

	logic         issue;
	logic         issue_data; // Final access rather than a descriptor read
	ptr           issue_addr;
	logic         done;
	fault_cause_t cause_next;

	// Disabled path goes straight from core_req
	assign req_src = (state == IDLE) ? core_req : hold;

	always_comb begin
		state_next = state;
		issue = 1'b0;
		issue_data = 1'b0;
		issue_addr = '0;
		done = 1'b0;
		cause_next = CAUSE_NONE;

		unique case (state)
			IDLE:
				if (core_start) begin
					issue = 1'b1;
					if (mmu_enable) begin
						state_next = L1;
						issue_addr = {mmu_ttbr, l1_index(core_req.addr), 2'b00};
					end else begin
						state_next = DATA;
						issue_data = 1'b1;
						issue_addr = core_req.addr;
					end
				end

			L1:
				if (bus_ready) begin
					unique case (pagetable.desc_type)
						MMU_L1_PAGETABLE: begin
							state_next = L2;
							issue = 1'b1;
							issue_addr = {pagetable.base, l2_index(hold.addr), 2'b00};
						end
						MMU_L1_SECTION: begin
							state_next = DATA;
							issue = 1'b1;
							issue_data = 1'b1;
							issue_addr = {section.base, section_offset(hold.addr)};
						end
						MMU_L1_FAULT: begin
							state_next = FAULT;
							cause_next = CAUSE_L1_FAULT;
						end
						MMU_L1_RESERVED: begin // Fine tables not handled
							state_next = FAULT;
							cause_next = CAUSE_L1_UNSUPPORTED;
						end
					endcase
				end

			L2:
				if (bus_ready) begin
					unique case (ptentry_small.desc_type)
						MMU_L2_FAULT: begin
							state_next = FAULT;
							cause_next = CAUSE_L2_FAULT;
						end
						MMU_L2_LARGE: begin
							state_next = DATA;
							issue = 1'b1;
							issue_data = 1'b1;
							issue_addr = {ptentry_large.base, large_offset(hold.addr)};
						end
						MMU_L2_SMALL, MMU_L2_SMALLEXT: begin
							state_next = DATA;
							issue = 1'b1;
							issue_data = 1'b1;
							issue_addr = {ptentry_small.base, small_offset(hold.addr)};
						end
					endcase
				end

			DATA:
				if (bus_ready) begin
					state_next = IDLE;
					done = 1'b1;
				end

			FAULT:
				state_next = IDLE; // One cycle of fault response
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			bus_start <= 1'b0;
			bus_write <= 1'b0;
			data_done <= 1'b0;
		end else begin
			state <= state_next;
			bus_start <= issue;
			data_done <= done;

			if (issue)
				bus_write <= issue_data && req_src.write; // Descriptor reads never write
			else if (done)
				bus_write <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && core_start)
			hold <= core_req;

		if (issue) begin
			bus_addr <= issue_addr;
			bus_data_wr <= req_src.data_wr;
			bus_be <= issue_data ? req_src.be : 4'hf;
		end

		if (done)
			core_data_rd <= bus_data_rd;

		if (cause_next != CAUSE_NONE)
			cause_q <= cause_next;
	end

	assign bus_req = '{addr: bus_addr, data_wr: bus_data_wr, be: bus_be, write: bus_write};

	assign core_ready = data_done || state == FAULT;
	assign core_fault = state == FAULT;
	assign fault_strobe = state == FAULT;
	assign fault_addr = hold.addr;
	assign fault_cause = cause_q;

	no_start_at_ready: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(bus_start && core_ready)
	);

	start_only_idle: assert property (
		@(posedge clk) disable iff (!rst_n)
		core_start |-> state == IDLE
	);

endmodule

// ==== hw/core_mmu_pkg.sv ====
package core_mmu_pkg;

	typedef logic [31:0] word;
	typedef logic [31:0] ptr;

	// Upper bits of the first-level table address
	typedef logic [17:0] mmu_base;

	typedef struct packed {
		logic [21:0] base; // 1 KiB aligned L2 table
		logic [7:0]  ignored;
		logic [1:0]  desc_type;
	} mmu_l1_pagetable;

	typedef struct packed {
		logic [11:0] base; // 1 MiB section
		logic [17:0] ignored;
		logic [1:0]  desc_type;
	} mmu_l1_section;

	typedef struct packed {
		logic [15:0] base; // 64 KiB page
		logic [13:0] ignored;
		logic [1:0]  desc_type;
	} mmu_l2_large;

	typedef struct packed {
		logic [19:0] base; // 4 KiB page
		logic [9:0]  ignored;
		logic [1:0]  desc_type;
	} mmu_l2_small;

	localparam logic [1:0] MMU_L1_FAULT     = 2'd0;
	localparam logic [1:0] MMU_L1_PAGETABLE = 2'd1;
	localparam logic [1:0] MMU_L1_SECTION   = 2'd2;
	localparam logic [1:0] MMU_L1_RESERVED  = 2'd3;

	localparam logic [1:0] MMU_L2_FAULT     = 2'd0;
	localparam logic [1:0] MMU_L2_LARGE     = 2'd1;
	localparam logic [1:0] MMU_L2_SMALL     = 2'd2;
	localparam logic [1:0] MMU_L2_SMALLEXT  = 2'd3;

	// Same layout on the core side and the bus side
	typedef struct packed {
		ptr         addr;
		word        data_wr;
		logic [3:0] be;
		logic       write;
	} mem_req_t;

	typedef enum logic [1:0] {
		CAUSE_NONE,
		CAUSE_L1_FAULT,
		CAUSE_L1_UNSUPPORTED,
		CAUSE_L2_FAULT
	} fault_cause_t;

	function automatic logic [11:0] l1_index(ptr va);
		return va[31:20];
	endfunction

	function automatic logic [7:0] l2_index(ptr va);
		return va[19:12];
	endfunction

	function automatic logic [19:0] section_offset(ptr va);
		return va[19:0];
	endfunction

	function automatic logic [15:0] large_offset(ptr va);
		return va[15:0];
	endfunction

	function automatic logic [11:0] small_offset(ptr va);
		return va[11:0];
	endfunction

endpackage

// ==== hw/core_mmu_ram.sv ====
`timescale 1ns/1ps

module core_mmu_ram
	import core_mmu_pkg::*;
#(
	parameter int RAM_ADDR_BITS = 16, // Byte address bits
	parameter int RAM_LATENCY = 2
)
(
	input  logic     clk,
	input  logic     rst_n,

	input  mem_req_t bus_req,
	input  logic     bus_start,

	input  logic     load_we,
	input  ptr       load_addr,
	input  word      load_data,

	output logic     bus_ready,
	output word      bus_data_rd
);

	localparam int WORDS = 2 ** (RAM_ADDR_BITS - 2);

	word mem [WORDS];

	// Upper address bits drop off so accesses wrap
	logic [RAM_ADDR_BITS-3:0] bus_idx;
	logic [RAM_ADDR_BITS-3:0] load_idx;

	logic [RAM_LATENCY-1:0] pending;
	word rd_q;

	assign bus_idx = bus_req.addr[RAM_ADDR_BITS-1:2];
	assign load_idx = load_addr[RAM_ADDR_BITS-1:2];

	always_ff @(posedge clk) begin
		if (load_we) begin
			mem[load_idx] <= load_data;
		end else if (bus_start && bus_req.write) begin
			for (int i = 0; i < 4; i++)
				if (bus_req.be[i])
					mem[bus_idx][i*8 +: 8] <= bus_req.data_wr[i*8 +: 8];
		end

		// Read before write, only one request in flight
		if (bus_start)
			rd_q <= mem[bus_idx];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pending <= '0;
		else
			pending <= (pending << 1) | RAM_LATENCY'(bus_start);
	end

	assign bus_ready = pending[RAM_LATENCY-1];
	assign bus_data_rd = rd_q;

	one_in_flight: assert property (
		@(posedge clk) disable iff (!rst_n)
		bus_start |-> pending == '0
	);

endmodule

// ==== hw/core_mmu_top.sv ====
`timescale 1ns/1ps

module core_mmu_top
	import core_mmu_pkg::*;
#(
	parameter int RAM_ADDR_BITS = 16,
	parameter int RAM_LATENCY = 2
)
(
	input  logic         clk,
	input  logic         rst_n,

	input  logic         cfg_we,
	input  logic         cfg_enable,
	input  mmu_base      cfg_ttbr,

	input  logic         load_we,
	input  ptr           load_addr,
	input  word          load_data,

	input  mem_req_t     core_req,
	input  logic         core_start,
	output logic         core_ready,
	output word          core_data_rd,
	output logic         core_fault,

	output logic         fault_valid,
	output ptr           fault_status_addr,
	output fault_cause_t fault_status_cause
);

	logic         mmu_enable;
	mmu_base      mmu_ttbr;

	logic         fault_strobe;
	ptr           fault_addr;
	fault_cause_t fault_cause;

	mem_req_t     bus_req;
	logic         bus_start;
	logic         bus_ready;
	word          bus_data_rd;

	core_mmu_ctrl core_mmu_ctrl_i (
		.clk,
		.rst_n,
		.cfg_we,
		.cfg_enable,
		.cfg_ttbr,
		.fault_strobe,
		.fault_addr,
		.fault_cause,
		.mmu_enable,
		.mmu_ttbr,
		.fault_valid,
		.fault_status_addr,
		.fault_status_cause
	);

	core_mmu_pagewalk core_mmu_pagewalk_i (
		.clk,
		.rst_n,
		.mmu_enable,
		.mmu_ttbr,
		.core_req,
		.core_start,
		.bus_ready,
		.bus_data_rd,
		.bus_req,
		.bus_start,
		.core_ready,
		.core_data_rd,
		.core_fault,
		.fault_strobe,
		.fault_addr,
		.fault_cause
	);

	core_mmu_ram #(
		.RAM_ADDR_BITS(RAM_ADDR_BITS),
		.RAM_LATENCY(RAM_LATENCY)
	) core_mmu_ram_i (
		.clk,
		.rst_n,
		.bus_req,
		.bus_start,
		.load_we,
		.load_addr,
		.load_data,
		.bus_ready,
		.bus_data_rd
	);

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the MMU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module core_mmu_tb -f tb.f -o core_mmu_sim
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/core_mmu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	exit 1
fi

if ! grep -q "TEST PASSED" "$LOG"; then
	echo "No result line in $LOG"
	exit 1
fi

exit 0

// ==== tb.f ====
hw/core_mmu_pkg.sv
hw/core_mmu_ctrl.sv
hw/core_mmu_pagewalk.sv
hw/core_mmu_ram.sv
hw/core_mmu_top.sv
bench/core_mmu_check.sv
bench/core_mmu_tb.sv
